// ==== ofmap_acc_top.f ====
rtl/acc_pkg.sv
rtl/pe_row.sv
rtl/acc_counter.sv
rtl/acc_ctrl.sv
rtl/acc_buffer.sv
rtl/ofmap_acc_top.sv
tb/ofmap_acc_assert.sv
tb/ofmap_acc_tb.sv

// ==== Bender.yml ====
package:
  name: ofmap_acc

sources:
  - rtl/acc_pkg.sv
  - rtl/pe_row.sv
  - rtl/acc_counter.sv
  - rtl/acc_ctrl.sv
  - rtl/acc_buffer.sv
  - rtl/ofmap_acc_top.sv
  - target: simulation
    files:
      - tb/ofmap_acc_assert.sv
      - tb/ofmap_acc_tb.sv

// ==== tb/ofmap_acc_tb.sv ====
`timescale 1ns/1ps

module ofmap_acc_tb;

    import acc_pkg::*;

    localparam int BUS_W      = PE_SIZE * DATA_W;
    localparam int WAIT_LIMIT = 200;
    localparam int EARLY_BEATS = (ACC_CNT_NUM - 1) * WEIGHT_COL_NUM;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic                 compute_en;
    logic [BUS_W-1:0]     ifmap_data;
    logic [BUS_W-1:0]     weight_data;
    logic                 ofmap_valid;
    logic [COL_IDX_W-1:0] ofmap_col;
    logic [ACC_W-1:0]     ofmap_data;
    logic                 busy;
    logic                 done;

    logic [31:0] rng_state;
    int          errors;
    int          compared;
    int          strobe_cnt;
    int          done_cnt;
    int          beats_sent;
    int          frames_run;
    string       test_name;
    logic        done_prev;
    logic        busy_prev;

    // Frame stimulus by tile and column
    logic [BUS_W-1:0] ifm_frame [ACC_CNT_NUM][WEIGHT_COL_NUM];
    logic [BUS_W-1:0] wgt_frame [ACC_CNT_NUM][WEIGHT_COL_NUM];
    int               exp_col_q [$];
    int               exp_val_q [$];

    ofmap_acc_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .compute_en  (compute_en),
        .ifmap_data  (ifmap_data),
        .weight_data (weight_data),
        .ofmap_valid (ofmap_valid),
        .ofmap_col   (ofmap_col),
        .ofmap_data  (ofmap_data),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word from the upper halves of two LCG steps
    task automatic rand_word(output logic [31:0] w);
        logic [15:0] hi;
        rng_state = lcg_next(rng_state);
        hi = rng_state[31:16];
        rng_state = lcg_next(rng_state);
        w = {hi, rng_state[31:16]};
    endtask

    task automatic rand_below(input int n, output int r);
        logic [31:0] w;
        rand_word(w);
        r = int'(w % n);
    endtask

    task automatic fill_frame(input bit saturate);
        logic [31:0] w;
        for (int t = 0; t < ACC_CNT_NUM; t++) begin
            for (int c = 0; c < WEIGHT_COL_NUM; c++) begin
                if (saturate) begin
                    ifm_frame[t][c] = '1;
                    wgt_frame[t][c] = '1;
                end else begin
                    rand_word(w);
                    ifm_frame[t][c] = BUS_W'(w);
                    rand_word(w);
                    wgt_frame[t][c] = BUS_W'(w);
                end
            end
        end
    endtask

    // Column sums over every tile and lane at full width
    task automatic build_model();
        int sum;
        int a;
        int b;
        for (int c = 0; c < WEIGHT_COL_NUM; c++) begin
            sum = 0;
            for (int t = 0; t < ACC_CNT_NUM; t++) begin
                for (int k = 0; k < PE_SIZE; k++) begin
                    a = int'(ifm_frame[t][c][k*DATA_W +: DATA_W]);
                    b = int'(wgt_frame[t][c][k*DATA_W +: DATA_W]);
                    sum = sum + a * b;
                end
            end
            exp_col_q.push_back(c);
            exp_val_q.push_back(sum);
        end
    endtask

    task automatic drive_idle_beats(input int count);
        logic [31:0] w;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            rand_word(w);
            ifmap_data <= BUS_W'(w);
            rand_word(w);
            weight_data <= BUS_W'(w);
            compute_en <= 1'b1;
        end
        @(posedge clk);
        compute_en <= 1'b0;
    endtask

    task automatic start_frame();
        strobe_cnt = 0;
        beats_sent = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(negedge clk);
            if (busy) begin
                break;
            end
        end
        if (!busy) begin
            errors++;
            $display("Timeout in %s: busy never rose after start", test_name);
        end
    endtask

    task automatic stream_frame(input int gap_pct);
        int          n;
        int          g;
        logic [31:0] w;
        for (int t = 0; t < ACC_CNT_NUM; t++) begin
            for (int c = 0; c < WEIGHT_COL_NUM; c++) begin
                rand_below(100, n);
                if (n < gap_pct) begin
                    rand_below(3, g);
                    for (int j = 0; j <= g; j++) begin
                        @(posedge clk);
                        compute_en <= 1'b0;
                    end
                end
                @(posedge clk);
                ifmap_data  <= ifm_frame[t][c];
                weight_data <= wgt_frame[t][c];
                compute_en  <= 1'b1;
                beats_sent++;
            end
        end
        // Extra beat right behind the last one must be dropped
        @(posedge clk);
        rand_word(w);
        ifmap_data <= BUS_W'(w);
        rand_word(w);
        weight_data <= BUS_W'(w);
        compute_en <= 1'b1;
        @(posedge clk);
        compute_en <= 1'b0;
    endtask

    task automatic wait_done();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout in %s: done never rose", test_name);
        end else if (busy) begin
            errors++;
            $display("In %s busy was still high in the done cycle", test_name);
        end
    endtask

    task automatic run_frame(input int gap_pct, input bit saturate, input bit settle);
        fill_frame(saturate);
        build_model();
        start_frame();
        stream_frame(gap_pct);
        wait_done();
        @(posedge clk);
        frames_run++;
        if (strobe_cnt != WEIGHT_COL_NUM) begin
            errors++;
            $display("ERR %s strobes expected %0d actual %0d",
                     test_name, WEIGHT_COL_NUM, strobe_cnt);
        end
        if (done_cnt != frames_run) begin
            errors++;
            $display("ERR %s done pulses expected %0d actual %0d",
                     test_name, frames_run, done_cnt);
        end
        if (exp_col_q.size() != 0) begin
            errors++;
            $display("In %s %0d expected values got no ofmap strobe",
                     test_name, exp_col_q.size());
            exp_col_q.delete();
            exp_val_q.delete();
        end
        if (settle) begin
            repeat (4) @(negedge clk);
            if (busy) begin
                errors++;
                $display("In %s busy rose again after done", test_name);
            end
            if (done_cnt != frames_run) begin
                errors++;
                $display("ERR %s done pulses expected %0d actual %0d",
                         test_name, frames_run, done_cnt);
            end
        end
    endtask

    task automatic check_ofmap();
        int exp_c;
        int exp_v;
        strobe_cnt++;
        compared++;
        if (beats_sent <= EARLY_BEATS) begin
            errors++;
            $display("In %s an ofmap strobe came before the last tile", test_name);
        end
        if (exp_col_q.size() == 0) begin
            errors++;
            $display("In %s an ofmap strobe came with no value expected (column %0d)",
                     test_name, ofmap_col);
        end else begin
            exp_c = exp_col_q.pop_front();
            exp_v = exp_val_q.pop_front();
            if (ofmap_col !== COL_IDX_W'(exp_c)) begin
                errors++;
                $display("ERR %s column expected %0d actual %0d", test_name, exp_c, ofmap_col);
            end
            if ({{(32-ACC_W){1'b0}}, ofmap_data} !== 32'(exp_v)) begin
                errors++;
                $display("ERR %s column %0d value expected %0d actual %0d",
                         test_name, exp_c, exp_v, ofmap_data);
            end
        end
    endtask

    // Output monitor and control protocol checks
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) begin
                done_cnt++;
            end
            if (done && done_prev) begin
                errors++;
                $display("In %s done stayed high for two cycles", test_name);
            end
            if (done && !busy_prev) begin
                errors++;
                $display("In %s done rose without busy the cycle before", test_name);
            end
            if (ofmap_valid) begin
                check_ofmap();
            end
        end
        done_prev = done;
        busy_prev = busy;
    end

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        compute_en  = 1'b0;
        ifmap_data  = '0;
        weight_data = '0;
        rng_state   = 32'd16;
        errors      = 0;
        compared    = 0;
        strobe_cnt  = 0;
        done_cnt    = 0;
        beats_sent  = 0;
        frames_run  = 0;
        done_prev   = 1'b0;
        busy_prev   = 1'b0;
        test_name   = "reset";

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (busy || done || ofmap_valid) begin
            errors++;
            $display("Outputs were not idle after reset");
        end

        test_name = "idle_before_start";
        drive_idle_beats(12);
        test_name = "full_frame";
        run_frame(0, 1'b0, 1'b1);
        test_name = "gap_frame";
        run_frame(35, 1'b0, 1'b1);
        test_name = "idle_after_done";
        drive_idle_beats(12);
        repeat (3) @(negedge clk);
        test_name = "frame_after_idle";
        run_frame(20, 1'b0, 1'b1);
        test_name = "back_to_back_a";
        run_frame(0, 1'b0, 1'b0);
        test_name = "back_to_back_b";
        run_frame(15, 1'b0, 1'b1);
        test_name = "all_bytes_255";
        run_frame(0, 1'b1, 1'b1);

        $display("Summary: %0d errors, %0d ofmap values checked over %0d frames",
                 errors, compared, frames_run);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb/ofmap_acc_assert.sv ====
`timescale 1ns/1ps

module ofmap_acc_assert (
    input logic clk,
    input logic rst_n,
    input logic pe_en,
    input logic busy,
    input logic done,
    input logic ofmap_valid
);

    // Done is a single-cycle pulse
    a_done_single : assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // Beats are only taken inside a frame
    a_pe_en_busy : assert property (@(posedge clk) disable iff (!rst_n)
        pe_en |-> busy)
        else $error("pe_en high while busy is low");

    // Ofmap strobes belong to a running or finishing frame
    a_ofmap_in_frame : assert property (@(posedge clk) disable iff (!rst_n)
        ofmap_valid |-> (busy || done))
        else $error("ofmap_valid outside a frame");

    a_done_after_busy : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy))
        else $error("done without busy in the previous cycle");

endmodule

bind ofmap_acc_top ofmap_acc_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .pe_en       (pe_en),
    .busy        (busy),
    .done        (done),
    .ofmap_valid (ofmap_valid)
);

// ==== rtl/ofmap_acc_top.sv ====
`timescale 1ns/1ps

module ofmap_acc_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start,
    input  logic                                         compute_en,
    input  logic [acc_pkg::PE_SIZE*acc_pkg::DATA_W-1:0]  ifmap_data,
    input  logic [acc_pkg::PE_SIZE*acc_pkg::DATA_W-1:0]  weight_data,
    output logic                                         ofmap_valid,
    output logic [acc_pkg::COL_IDX_W-1:0]                ofmap_col,
    output logic [acc_pkg::ACC_W-1:0]                    ofmap_data,
    output logic                                         busy,
    output logic                                         done
);

    import acc_pkg::*;

    // Controller and counter
    logic                 pe_en;
    logic                 frame_done;
    logic [COL_IDX_W-1:0] col_idx;
    logic                 first_tile;
    logic                 last_tile;

    // PE row to buffer
    logic                 psum_valid;
    logic [PSUM_W-1:0]    psum_data;
    logic [COL_IDX_W-1:0] psum_col;
    logic                 psum_first;
    logic                 psum_last;

    acc_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .compute_en (compute_en),
        .frame_done (frame_done),
        .pe_en      (pe_en),
        .busy       (busy),
        .done       (done)
    );

    acc_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .pe_en      (pe_en),
        .col_idx    (col_idx),
        .first_tile (first_tile),
        .last_tile  (last_tile),
        .frame_done (frame_done)
    );

    // Beat tag comes straight from the counter registers
    pe_row u_pe_row (
        .clk         (clk),
        .rst_n       (rst_n),
        .pe_en       (pe_en),
        .ifmap_data  (ifmap_data),
        .weight_data (weight_data),
        .col_idx     (col_idx),
        .first_tile  (first_tile),
        .last_tile   (last_tile),
        .psum_valid  (psum_valid),
        .psum_data   (psum_data),
        .psum_col    (psum_col),
        .psum_first  (psum_first),
        .psum_last   (psum_last)
    );

    acc_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .psum_valid  (psum_valid),
        .psum_data   (psum_data),
        .psum_col    (psum_col),
        .psum_first  (psum_first),
        .psum_last   (psum_last),
        .ofmap_valid (ofmap_valid),
        .ofmap_col   (ofmap_col),
        .ofmap_data  (ofmap_data)
    );

endmodule

// ==== rtl/acc_buffer.sv ====
`timescale 1ns/1ps

module acc_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           psum_valid,
    input  logic [acc_pkg::PSUM_W-1:0]     psum_data,
    input  logic [acc_pkg::COL_IDX_W-1:0]  psum_col,
    input  logic                           psum_first,
    input  logic                           psum_last,
    output logic                           ofmap_valid,
    output logic [acc_pkg::COL_IDX_W-1:0]  ofmap_col,
    output logic [acc_pkg::ACC_W-1:0]      ofmap_data
);

    import acc_pkg::*;

    // One running sum per ofmap column
    logic [ACC_W-1:0] acc_mem [WEIGHT_COL_NUM];

    logic [ACC_W-1:0] acc_base;
    logic [ACC_W-1:0] acc_sum;
    logic             out_load;

    // First tile starts from zero so stale sums are dropped
    assign acc_base = psum_first ? '0 : acc_mem[psum_col];
    assign acc_sum  = acc_base + ACC_W'(psum_data);
    assign out_load = psum_valid && psum_last;

    always_ff @(posedge clk) begin
        if (psum_valid) begin
            acc_mem[psum_col] <= acc_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofmap_valid <= 1'b0;
        end else begin
            ofmap_valid <= out_load;
        end
    end

    // Completed sum leaves on the last tile
    always_ff @(posedge clk) begin
        if (out_load) begin
            ofmap_data <= acc_sum;
            ofmap_col  <= psum_col;
        end
    end

endmodule

// ==== rtl/acc_ctrl.sv ====
`timescale 1ns/1ps

module acc_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic compute_en,
    input  logic frame_done,
    output logic pe_en,
    output logic busy,
    output logic done
);

    import acc_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;

    // Set the cycle after the final beat, while the last sum drains
    logic frame_end;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                // Leave once the last psum has reached the buffer
                if (frame_end) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            frame_end <= 1'b0;
        end else begin
            state     <= state_nxt;
            frame_end <= frame_done;
        end
    end

    // No beat is taken after the final one of the frame
    assign pe_en = compute_en && (state == ST_RUN) && !frame_end;
    assign busy  = (state == ST_RUN);
    assign done  = (state == ST_DONE);

endmodule

// ==== rtl/acc_counter.sv ====
`timescale 1ns/1ps

module acc_counter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           pe_en,
    output logic [acc_pkg::COL_IDX_W-1:0]  col_idx,
    output logic                           first_tile,
    output logic                           last_tile,
    output logic                           frame_done
);

    import acc_pkg::*;

    localparam logic [COL_IDX_W-1:0]  LAST_COL  = COL_IDX_W'(WEIGHT_COL_NUM - 1);
    localparam logic [TILE_IDX_W-1:0] LAST_TILE = TILE_IDX_W'(ACC_CNT_NUM - 1);

    logic [COL_IDX_W-1:0]  psum_cnt;
    logic [COL_IDX_W-1:0]  psum_cnt_nxt;
    logic [TILE_IDX_W-1:0] acc_cnt;
    logic [TILE_IDX_W-1:0] acc_cnt_nxt;
    logic                  psum_wrap;

    // Column counter wraps on the last column of a tile
    assign psum_wrap = pe_en && (psum_cnt == LAST_COL);

    always_comb begin
        if (psum_wrap) begin
            psum_cnt_nxt = '0;
        end else if (pe_en) begin
            psum_cnt_nxt = psum_cnt + 1'b1;
        end else begin
            psum_cnt_nxt = psum_cnt;
        end
    end

    // Tile counter steps once per finished tile
    always_comb begin
        if (psum_wrap) begin
            if (acc_cnt == LAST_TILE) begin
                acc_cnt_nxt = '0;
            end else begin
                acc_cnt_nxt = acc_cnt + 1'b1;
            end
        end else begin
            acc_cnt_nxt = acc_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_cnt <= '0;
            acc_cnt  <= '0;
        end else begin
            psum_cnt <= psum_cnt_nxt;
            acc_cnt  <= acc_cnt_nxt;
        end
    end

    // Tag of the current beat
    assign col_idx    = psum_cnt;
    assign first_tile = (acc_cnt == '0);
    assign last_tile  = (acc_cnt == LAST_TILE);

    // Final beat of the frame
    assign frame_done = psum_wrap && last_tile;

endmodule

// ==== rtl/pe_row.sv ====
`timescale 1ns/1ps

module pe_row (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             pe_en,
    input  logic [acc_pkg::PE_SIZE*acc_pkg::DATA_W-1:0]      ifmap_data,
    input  logic [acc_pkg::PE_SIZE*acc_pkg::DATA_W-1:0]      weight_data,
    input  logic [acc_pkg::COL_IDX_W-1:0]                    col_idx,
    input  logic                                             first_tile,
    input  logic                                             last_tile,
    output logic                                             psum_valid,
    output logic [acc_pkg::PSUM_W-1:0]                       psum_data,
    output logic [acc_pkg::COL_IDX_W-1:0]                    psum_col,
    output logic                                             psum_first,
    output logic                                             psum_last
);

    import acc_pkg::*;

    localparam int PROD_W = 2 * DATA_W;
    localparam int PAIR_W = PROD_W + 1;
    localparam int PAIR_NUM = PE_SIZE / 2;

    logic [PROD_W-1:0] prod [PE_SIZE];
    logic [PAIR_W-1:0] pair_sum [PAIR_NUM];
    logic [PSUM_W-1:0] tree_sum;

    // One unsigned multiplier per element lane
    for (genvar k = 0; k < PE_SIZE; k++) begin : g_mul
        assign prod[k] = ifmap_data[k*DATA_W +: DATA_W] * weight_data[k*DATA_W +: DATA_W];
    end

    // First tree level adds neighbouring lanes
    for (genvar p = 0; p < PAIR_NUM; p++) begin : g_pair
        assign pair_sum[p] = PAIR_W'(prod[2*p]) + PAIR_W'(prod[2*p+1]);
    end

    // Remaining level folds the pair sums
    always_comb begin
        tree_sum = '0;
        for (int p = 0; p < PAIR_NUM; p++) begin
            tree_sum = tree_sum + PSUM_W'(pair_sum[p]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_valid <= 1'b0;
        end else begin
            psum_valid <= pe_en;
        end
    end

    // Sum and tag move together, qualified by psum_valid
    always_ff @(posedge clk) begin
        if (pe_en) begin
            psum_data  <= tree_sum;
            psum_col   <= col_idx;
            psum_first <= first_tile;
            psum_last  <= last_tile;
        end
    end

endmodule

// ==== rtl/acc_pkg.sv ====
package acc_pkg;

    // Element width of ifmap and weight bytes, unsigned
    localparam int DATA_W = 8;

    // Multipliers per PE row, also rows per tile
    localparam int PE_SIZE = 4;

    // Weight matrix geometry
    localparam int WEIGHT_ROW_NUM = 16;
    localparam int WEIGHT_COL_NUM = 8;

    // Tiles per frame
    localparam int ACC_CNT_NUM = WEIGHT_ROW_NUM / PE_SIZE;

    // Index widths
    localparam int COL_IDX_W  = $clog2(WEIGHT_COL_NUM);
    localparam int TILE_IDX_W = $clog2(ACC_CNT_NUM);

    // Partial sum holds PE_SIZE full products
    localparam int PSUM_W = 2 * DATA_W + $clog2(PE_SIZE);

    // Accumulated value holds ACC_CNT_NUM partial sums
    localparam int ACC_W = PSUM_W + $clog2(ACC_CNT_NUM);

    // Frame controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } ctrl_state_e;

endpackage
